// File: run.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f sources.f -o dcache_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
	exit 0
else
	exit 1
fi

// File: sim/dcache_stim.txt
// op cacheable address wdata wmask expected_rdata expect_hit (hex fields)
// expect_hit 1 means o_ready two cycles after the request rises
write 1 00000010 11112222 f 00000000 1
read 1 00000010 00000000 0 11112222 1
read 1 00000020 00000000 0 00000000 0
read 1 00000020 00000000 0 00000000 1
write 1 00000014 aaaa0001 f 00000000 1
write 1 00000054 bbbb0002 f 00000000 0
read 1 00000014 00000000 0 aaaa0001 0
read 1 00000014 00000000 0 aaaa0001 1
write 0 00000030 0bad0030 f 00000000 0
write 1 00000030 c0de0030 f 00000000 1
read 0 00000030 00000000 0 0bad0030 0
flush 0 00000000 00000000 0 00000000 0
read 0 00000030 00000000 0 c0de0030 0
write 0 00000100 12345678 f 00000000 0
write 0 00000100 aabbccdd 5 00000000 0
read 0 00000100 00000000 0 12bb56dd 0
read 1 00000010 00000000 0 11112222 1
read 1 00000030 00000000 0 c0de0030 1
read 0 00000010 00000000 0 11112222 0
idle 0 00000000 00000000 0 00000000 0
read 1 00000054 00000000 0 bbbb0002 0
read 1 00000054 00000000 0 bbbb0002 1

// File: sim/dcache_tb.sv
// Data cache testbench: stim file loader, CPU request driver, checks and watchdog.
module dcache_tb import dcache_pkg::*; ();

	localparam int INDEX_WIDTH = 4;
	localparam int MEM_ADDRESS_WIDTH = 10;
	localparam int WAIT_CYCLES = 3;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 1;
	localparam int HIT_LATENCY = 2;

	localparam logic [1:0] OP_READ = 2'd0;
	localparam logic [1:0] OP_WRITE = 2'd1;
	localparam logic [1:0] OP_FLUSH = 2'd2;
	localparam logic [1:0] OP_IDLE = 2'd3;

	// One line of the stim file.
	typedef struct packed {
		logic [1:0]            op;
		logic                  cacheable;
		logic [WORD_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] wdata;
		logic [MASK_WIDTH-1:0] wmask;
		logic [WORD_WIDTH-1:0] expected;
		logic                  expect_hit;
	} stim_t;

	logic                  clock = 1'b0;
	logic                  reset;
	cpu_req_t              cpu_req;
	logic                  ready;
	logic [WORD_WIDTH-1:0] rdata;

	stim_t stim_q[$];
	int    mismatch_count = 0;
	int    failure_count = 0;
	int    cycle_count = 0;
	int    cycle_limit;

	dcache_top #(
		.INDEX_WIDTH(INDEX_WIDTH),
		.MEM_ADDRESS_WIDTH(MEM_ADDRESS_WIDTH),
		.WAIT_CYCLES(WAIT_CYCLES)
	) dcache_top_i (
		.i_clock(clock),
		.i_reset(reset),
		.i_cpu_req(cpu_req),
		.o_ready(ready),
		.o_rdata(rdata)
	);

	always #2 clock = ~clock;

	// ============================================================
	// Helpers
	// ============================================================

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("Result: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// Lines starting with a // token are skipped.
	task automatic load_stim();
		integer           fd;
		integer           code;
		logic [63:0]      token;
		logic [8*256-1:0] rest;
		logic [31:0]      cacheable;
		logic [31:0]      address;
		logic [31:0]      wdata;
		logic [31:0]      wmask;
		logic [31:0]      expected;
		logic [31:0]      hit;
		stim_t            entry;
		fd = $fopen("sim/dcache_stim.txt", "r");
		if (fd == 0) begin
			failure_count++;
			$display("Could not open the stimulus file sim/dcache_stim.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", token);
			if (code != 1) begin
				break;
			end
			if (token == 64'("//")) begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h %h %h", cacheable, address, wdata, wmask,
					expected, hit);
				if (code != 6) begin
					failure_count++;
					$display("Stimulus line for operation %0s has missing fields", token);
					break;
				end
				if (token == 64'("read")) begin
					entry.op = OP_READ;
				end else if (token == 64'("write")) begin
					entry.op = OP_WRITE;
				end else if (token == 64'("flush")) begin
					entry.op = OP_FLUSH;
				end else if (token == 64'("idle")) begin
					entry.op = OP_IDLE;
				end else begin
					failure_count++;
					$display("Unknown operation %0s in the stimulus file", token);
					break;
				end
				entry.cacheable = cacheable[0];
				entry.address = address;
				entry.wdata = wdata;
				entry.wmask = wmask[MASK_WIDTH-1:0];
				entry.expected = expected;
				entry.expect_hit = hit[0];
				stim_q.push_back(entry);
			end
		end
		$fclose(fd);
	endtask

	// Called one drive delay after a rising edge, returns at the same point.
	task automatic run_operation(input stim_t op, input int number);
		cpu_req_t req;
		int       cycles;
		logic     ready_seen;
		if (op.op == OP_IDLE) begin
			@(posedge clock);
			#DRIVE_DELAY;
			return;
		end
		req = '0;
		req.request = 1'b1;
		req.rw = (op.op == OP_WRITE);
		req.flush = (op.op == OP_FLUSH);
		req.cacheable = op.cacheable;
		req.address = op.address;
		req.wdata = op.wdata;
		req.wmask = op.wmask;
		cpu_req = req;

		// Count cycles up to and including the ready cycle.
		cycles = 0;
		ready_seen = 1'b0;
		while (!ready_seen) begin
			@(negedge clock);
			cycles++;
			ready_seen = ready;
		end

		if (op.op == OP_READ) begin
			check_value($sformatf("o_rdata in operation %0d", number), rdata, op.expected);
		end
		if (op.expect_hit) begin
			check_value($sformatf("ready latency in operation %0d", number), cycles,
				HIT_LATENCY);
		end else if (cycles <= HIT_LATENCY) begin
			failure_count++;
			$display("Operation %0d was expected to miss but finished in %0d cycles",
				number, cycles);
		end

		// Drop the request for one cycle.
		@(posedge clock);
		#DRIVE_DELAY;
		cpu_req = '0;
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	// ============================================================
	// Watchdog
	// ============================================================

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			failure_count++;
			$display("Timeout, the run did not finish within %0d cycles", cycle_limit);
			finish_run();
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		reset = 1'b1;
		cpu_req = '0;
		cycle_limit = RESET_CYCLES + (1 << INDEX_WIDTH) + 20;
		load_stim();
		if (stim_q.size() == 0) begin
			failure_count++;
			$display("No stimulus lines were loaded");
			finish_run();
		end else begin
			cycle_limit = cycle_limit + 40 * stim_q.size();

			repeat (RESET_CYCLES) @(posedge clock);
			#DRIVE_DELAY;
			reset = 1'b0;

			// Entry invalidation walk, one index per cycle.
			repeat ((1 << INDEX_WIDTH) + 2) @(posedge clock);
			#DRIVE_DELAY;

			for (int i = 0; i < stim_q.size(); i++) begin
				run_operation(stim_q[i], i + 1);
			end
			finish_run();
		end
	end

endmodule

// File: sources.f
src/dcache_pkg.sv
src/dcache_ram.sv
src/dcache_ctrl.sv
src/bus_memory.sv
src/dcache_top.sv
sim/dcache_tb.sv

// File: src/bus_memory.sv
// Backing memory bus slave with fixed wait states and byte-masked writes.
module bus_memory import dcache_pkg::*; #(
	parameter int ADDRESS_WIDTH = 10,
	parameter int WAIT_CYCLES = 3
) (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  bus_req_t              i_bus_req,
	output logic                  o_bus_ready,
	output logic [WORD_WIDTH-1:0] o_bus_rdata
);

	localparam int DEPTH = 1 << ADDRESS_WIDTH;
	localparam int COUNT_WIDTH = $clog2(WAIT_CYCLES + 2);

	logic [WORD_WIDTH-1:0]    mem [DEPTH];
	logic [COUNT_WIDTH-1:0]   wait_count;
	logic [ADDRESS_WIDTH-1:0] word_address;
	logic                     fire;

	// Zero at power-up only.
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign word_address = i_bus_req.address[ADDRESS_WIDTH + 1:2];

	// Last wait cycle of a live request.
	assign fire = !i_reset && i_bus_req.request && !o_bus_ready &&
		(wait_count == COUNT_WIDTH'(WAIT_CYCLES));

	// ============================================================
	// Wait state counter
	// ============================================================

	// Counter is held at zero in the ready cycle, so a request that
	// stays high afterwards starts a fresh transfer.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= fire;
			if (!i_bus_req.request || o_bus_ready || fire) begin
				wait_count <= '0;
			end else begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	// ============================================================
	// Memory array
	// ============================================================

	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_bus_req.rw) begin
				for (int b = 0; b < MASK_WIDTH; b++) begin
					if (i_bus_req.wmask[b]) begin
						mem[word_address][8*b +: 8] <= i_bus_req.wdata[8*b +: 8];
					end
				end
			end
			o_bus_rdata <= mem[word_address];
		end
	end

endmodule

// File: src/dcache_ctrl.sv
// Data cache controller FSM: initialise, hit/miss handling, write-back, pass-through and flush.
module dcache_ctrl import dcache_pkg::*; #(
	parameter int INDEX_WIDTH = 4
) (
	input  logic                   i_clock,
	input  logic                   i_reset,

	// CPU side.
	input  cpu_req_t               i_cpu_req,
	output logic                   o_ready,
	output logic [WORD_WIDTH-1:0]  o_rdata,

	// Bus side.
	output bus_req_t               o_bus_req,
	input  logic                   i_bus_ready,
	input  logic [WORD_WIDTH-1:0]  i_bus_rdata,

	// Entry RAM.
	output logic                   o_ram_write,
	output logic [INDEX_WIDTH-1:0] o_ram_index,
	output cache_entry_t           o_ram_wdata,
	input  cache_entry_t           i_ram_rdata
);

	typedef enum logic [3:0] {
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		FLUSH_NEXT,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT,
		INITIALIZE
	} state_t;

	state_t state;
	state_t next_state;

	// Walk counter for init and flush, top bit marks the end.
	logic [INDEX_WIDTH:0] flush_index;
	logic [INDEX_WIDTH:0] next_flush_index;
	logic                 flush_done;

	logic [INDEX_WIDTH-1:0] cpu_index;
	logic [TAG_WIDTH-1:0]   cpu_tag;
	logic                   hit;
	logic                   victim_dirty;

	// Full-word write-back of the entry currently read out.
	function automatic bus_req_t victim_write(cache_entry_t entry);
		bus_req_t req;
		req.request = 1'b1;
		req.rw = 1'b1;
		req.address = {entry.tag, 2'b00};
		req.wdata = entry.data;
		req.wmask = '1;
		return req;
	endfunction

	// Refill read of a word.
	function automatic bus_req_t refill_read(logic [WORD_WIDTH-1:0] address);
		bus_req_t req;
		req = '0;
		req.request = 1'b1;
		req.address = address;
		return req;
	endfunction

	// Uncached request forwarded as is.
	function automatic bus_req_t forward(cpu_req_t cpu);
		bus_req_t req;
		req.request = cpu.request;
		req.rw = cpu.rw;
		req.address = cpu.address;
		req.wdata = cpu.wdata;
		req.wmask = cpu.wmask;
		return req;
	endfunction

	assign cpu_index = i_cpu_req.address[INDEX_WIDTH + 1:2];
	assign cpu_tag = i_cpu_req.address[WORD_WIDTH - 1:2];
	assign flush_done = flush_index[INDEX_WIDTH];

	// Entry output belongs to the index presented one cycle earlier.
	assign hit = i_ram_rdata.valid && (i_ram_rdata.tag == cpu_tag);
	assign victim_dirty = i_ram_rdata.dirty && (i_ram_rdata.tag != cpu_tag);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			flush_index <= '0;
		end else begin
			state <= next_state;
			flush_index <= next_flush_index;
		end
	end

	always_comb begin
		next_state = state;
		next_flush_index = flush_index;
		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_req = '0;
		o_ram_write = 1'b0;
		o_ram_index = cpu_index;
		o_ram_wdata = '0;

		case (state)
			IDLE: begin
				if (i_cpu_req.request) begin
					if (i_cpu_req.flush) begin
						next_flush_index = '0;
						next_state = FLUSH_SETUP;
					end else if (!i_cpu_req.cacheable) begin
						o_bus_req = forward(i_cpu_req);
						next_state = PASS_THROUGH;
					end else if (i_cpu_req.rw) begin
						next_state = WRITE_SETUP;
					end else begin
						next_state = READ_SETUP;
					end
				end
			end

			// ============================================================
			// Flush
			// ============================================================

			FLUSH_SETUP: begin
				o_ram_index = flush_index[INDEX_WIDTH-1:0];
				if (flush_done) begin
					o_ready = 1'b1;
					next_state = IDLE;
				end else begin
					next_state = FLUSH_CHECK;
				end
			end

			FLUSH_CHECK: begin
				o_ram_index = flush_index[INDEX_WIDTH-1:0];
				if (i_ram_rdata.dirty) begin
					o_bus_req = victim_write(i_ram_rdata);
					next_state = FLUSH_WRITE;
				end else begin
					next_flush_index = flush_index + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end

			FLUSH_WRITE: begin
				o_ram_index = flush_index[INDEX_WIDTH-1:0];
				o_bus_req = victim_write(i_ram_rdata);
				if (i_bus_ready) begin
					// Entry stays valid, now clean.
					o_ram_write = 1'b1;
					o_ram_wdata = i_ram_rdata;
					o_ram_wdata.dirty = 1'b0;
					next_state = FLUSH_NEXT;
				end
			end

			FLUSH_NEXT: begin
				next_flush_index = flush_index + 1'b1;
				next_state = FLUSH_SETUP;
			end

			// ============================================================
			// Uncached
			// ============================================================

			PASS_THROUGH: begin
				o_bus_req = forward(i_cpu_req);
				o_rdata = i_bus_rdata;
				o_ready = i_bus_ready;
				if (!i_cpu_req.request) begin
					next_state = IDLE;
				end
			end

			// ============================================================
			// Cached write
			// ============================================================

			WRITE_SETUP: begin
				if (victim_dirty) begin
					o_bus_req = victim_write(i_ram_rdata);
					next_state = WRITE_WAIT;
				end else begin
					o_ram_write = 1'b1;
					o_ram_wdata = '{data: i_cpu_req.wdata, tag: cpu_tag, dirty: 1'b1, valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// Victim on the bus, store once it is out.
			WRITE_WAIT: begin
				o_bus_req = victim_write(i_ram_rdata);
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = '{data: i_cpu_req.wdata, tag: cpu_tag, dirty: 1'b1, valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ============================================================
			// Cached read
			// ============================================================

			READ_SETUP: begin
				if (hit) begin
					o_rdata = i_ram_rdata.data;
					o_ready = 1'b1;
					next_state = IDLE;
				end else if (i_ram_rdata.dirty) begin
					o_bus_req = victim_write(i_ram_rdata);
					next_state = READ_WB_WAIT;
				end else begin
					o_bus_req = refill_read(i_cpu_req.address);
					next_state = READ_BUS_WAIT;
				end
			end

			READ_WB_WAIT: begin
				o_bus_req = victim_write(i_ram_rdata);
				if (i_bus_ready) begin
					next_state = READ_BUS_WAIT;
				end
			end

			// Refill as clean and hand the word to the CPU.
			READ_BUS_WAIT: begin
				o_bus_req = refill_read(i_cpu_req.address);
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					o_ram_write = 1'b1;
					o_ram_wdata = '{data: i_bus_rdata, tag: cpu_tag, dirty: 1'b0, valid: 1'b1};
					o_ready = 1'b1;
					next_state = IDLE;
				end
			end

			// ============================================================
			// Initialise
			// ============================================================

			INITIALIZE: begin
				if (flush_done) begin
					next_flush_index = '0;
					next_state = IDLE;
				end else begin
					o_ram_write = 1'b1;
					o_ram_index = flush_index[INDEX_WIDTH-1:0];
					next_flush_index = flush_index + 1'b1;
				end
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

// File: src/dcache_pkg.sv
// Shared data cache types: word and field widths, CPU request, bus request and cache entry.
package dcache_pkg;

	// ============================================================
	// Field widths
	// ============================================================

	localparam int WORD_WIDTH = 32;
	localparam int MASK_WIDTH = WORD_WIDTH / 8;
	// Tag is the full word address, bits 31..2.
	localparam int TAG_WIDTH = WORD_WIDTH - 2;

	// ============================================================
	// Request structs
	// ============================================================

	// CPU side request, request level held until o_ready.
	typedef struct packed {
		logic                  request;
		logic                  rw;
		logic                  flush;
		logic                  cacheable;
		logic [WORD_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] wdata;
		logic [MASK_WIDTH-1:0] wmask;
	} cpu_req_t;

	// Bus side request towards the backing memory.
	typedef struct packed {
		logic                  request;
		logic                  rw;
		logic [WORD_WIDTH-1:0] address;
		logic [WORD_WIDTH-1:0] wdata;
		logic [MASK_WIDTH-1:0] wmask;
	} bus_req_t;

	// ============================================================
	// Cache entry
	// ============================================================

	// One entry per index, data word on top.
	typedef struct packed {
		logic [WORD_WIDTH-1:0] data;
		logic [TAG_WIDTH-1:0]  tag;
		logic                  dirty;
		logic                  valid;
	} cache_entry_t;

	localparam int ENTRY_WIDTH = $bits(cache_entry_t);

endpackage

// File: src/dcache_ram.sv
// Single-port synchronous RAM with one-cycle registered read, used for cache entries.
module dcache_ram #(
	parameter int ADDRESS_WIDTH = 4,
	parameter int DATA_WIDTH = 64
) (
	input  logic                     i_clock,
	input  logic                     i_write,
	input  logic [ADDRESS_WIDTH-1:0] i_address,
	input  logic [DATA_WIDTH-1:0]    i_wdata,
	output logic [DATA_WIDTH-1:0]    o_rdata
);

	localparam int DEPTH = 1 << ADDRESS_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_address] <= i_wdata;
		end
	end

	// Read port, registered on every edge.
	// A write in the same cycle returns the old word.
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_address];
	end

endmodule

// File: src/dcache_top.sv
// Data cache subsystem top: controller, entry RAM and backing memory.
module dcache_top import dcache_pkg::*; #(
	parameter int INDEX_WIDTH = 4,
	parameter int MEM_ADDRESS_WIDTH = 10,
	parameter int WAIT_CYCLES = 3
) (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  cpu_req_t              i_cpu_req,
	output logic                  o_ready,
	output logic [WORD_WIDTH-1:0] o_rdata
);

	// Controller to backing memory.
	bus_req_t              bus_req;
	logic                  bus_ready;
	logic [WORD_WIDTH-1:0] bus_rdata;

	// Controller to entry RAM.
	logic                   ram_write;
	logic [INDEX_WIDTH-1:0] ram_index;
	cache_entry_t           ram_wdata;
	cache_entry_t           ram_rdata;

	dcache_ctrl #(
		.INDEX_WIDTH(INDEX_WIDTH)
	) dcache_ctrl_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_cpu_req(i_cpu_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_req(bus_req),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata)
	);

	dcache_ram #(
		.ADDRESS_WIDTH(INDEX_WIDTH),
		.DATA_WIDTH(ENTRY_WIDTH)
	) dcache_ram_i (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_address(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	bus_memory #(
		.ADDRESS_WIDTH(MEM_ADDRESS_WIDTH),
		.WAIT_CYCLES(WAIT_CYCLES)
	) bus_memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_req(bus_req),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

endmodule
